//--- verilog/fcore_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set package of the floating point execution unit.
// Holds the opcode width and the opcode encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fcore_isa_pkg;

    localparam int OPCODE_WIDTH = 5;

    // Values not listed here are invalid and produce no result
    typedef enum logic [OPCODE_WIDTH-1:0] {
        ADD    = 5'd1,
        SUB    = 5'd2,
        MUL    = 5'd3,
        LDR    = 5'd5,
        BGT    = 5'd8,
        BLE    = 5'd9,
        BEQ    = 5'd10,
        BNE    = 5'd11,
        LAND   = 5'd16,
        LOR    = 5'd17,
        LNOT   = 5'd18,
        POPCNT = 5'd19,
        SATP   = 5'd20,
        SATN   = 5'd21
    } opcode_t;

endpackage

`default_nettype wire

//--- verilog/alu_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath types of the floating point execution unit: the float word
// union, the operand and result structs and the hidden bit helper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package alu_types_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 8;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp_fields_t;

    // The same word read as plain bits or as an IEEE 754 single
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        fp_fields_t            fields;
    } fp_word_u;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] dest;
        fp_word_u                  a;
        fp_word_u                  b;
    } alu_operand_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] dest;
        fp_word_u                  data;
    } alu_result_t;

    // An exponent of zero reads as zero, so it also drops the hidden bit
    function automatic logic [23:0] with_hidden(fp_fields_t f);
        return (f.exponent == 8'd0) ? 24'd0 : {1'b1, f.mantissa};
    endfunction

endpackage

`default_nettype wire

//--- verilog/delay_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed delay line for a word with its valid strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int WIDTH  = 40,
    parameter int STAGES = 1
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_word,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_word
);

    generate
        if (STAGES == 0) begin : g_bypass
            assign out_valid = in_valid;
            assign out_word  = in_word;
        end else begin : g_stages
            logic [STAGES-1:0] valid_q;
            logic [WIDTH-1:0]  word_q [STAGES];

            always_ff @(posedge clock) begin
                word_q[0] <= in_word;
                for (int i = 1; i < STAGES; i++) begin
                    word_q[i] <= word_q[i-1];
                end
                if (reset) begin
                    valid_q <= '0;
                end else begin
                    valid_q <= (valid_q << 1) | STAGES'(in_valid);
                end
            end

            assign out_valid = valid_q[STAGES-1];
            assign out_word  = word_q[STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/fp_add_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage single precision adder and subtractor.
// Truncating, normal numbers only, overflow saturates to infinity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fp_add_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  alu_types_pkg::alu_operand_t in,
    input  fcore_isa_pkg::opcode_t      opcode,
    output alu_types_pkg::alu_result_t  out
);

    alu_types_pkg::fp_fields_t op_a;
    alu_types_pkg::fp_fields_t op_b;
    logic                      swap;

    logic        s1_valid;
    logic [7:0]  s1_dest;
    logic        s1_sign;
    logic        s1_sub;
    logic [7:0]  s1_exp;
    logic [7:0]  s1_diff;
    logic [23:0] s1_big_mant;
    logic [23:0] s1_small_mant;
    logic [23:0] aligned;

    logic        s2_valid;
    logic [7:0]  s2_dest;
    logic        s2_sign;
    logic [7:0]  s2_exp;
    logic [24:0] s2_sum;

    logic [4:0]  lead;
    logic [23:0] shifted;
    logic [9:0]  norm_exp;
    logic [22:0] norm_mant;

    // Subtraction is addition with the sign of b flipped
    assign op_a = in.a.fields;
    always_comb begin
        op_b      = in.b.fields;
        op_b.sign = in.b.fields.sign ^ (opcode == fcore_isa_pkg::SUB);
    end
    assign swap = {op_b.exponent, op_b.mantissa} > {op_a.exponent, op_a.mantissa};

    always_ff @(posedge clock) begin
        s1_dest       <= in.dest;
        s1_sub        <= op_a.sign ^ op_b.sign;
        s1_sign       <= swap ? op_b.sign : op_a.sign;
        s1_exp        <= swap ? op_b.exponent : op_a.exponent;
        s1_diff       <= swap ? op_b.exponent - op_a.exponent : op_a.exponent - op_b.exponent;
        s1_big_mant   <= alu_types_pkg::with_hidden(swap ? op_b : op_a);
        s1_small_mant <= alu_types_pkg::with_hidden(swap ? op_a : op_b);
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in.valid;
        end
    end

    // Bits shifted out of the smaller operand are simply lost
    assign aligned = s1_small_mant >> s1_diff;

    always_ff @(posedge clock) begin
        s2_dest <= s1_dest;
        s2_sign <= s1_sign;
        s2_exp  <= s1_exp;
        if (s1_sub) begin
            s2_sum <= {1'b0, s1_big_mant} - {1'b0, aligned};
        end else begin
            s2_sum <= {1'b0, s1_big_mant} + {1'b0, aligned};
        end
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // Leading one search, the highest set bit sets the left shift
    always_comb begin
        lead = '0;
        for (int i = 0; i < 24; i++) begin
            if (s2_sum[i]) begin
                lead = 5'(23 - i);
            end
        end
        shifted = s2_sum[23:0] << lead;
        if (s2_sum[24]) begin
            norm_mant = s2_sum[23:1];
            norm_exp  = {2'b00, s2_exp} + 10'd1;
        end else begin
            norm_mant = shifted[22:0];
            norm_exp  = {2'b00, s2_exp} - {5'd0, lead};
        end
    end

    // A negative norm_exp wraps and shows up in bit 9
    always_ff @(posedge clock) begin
        out.dest <= s2_dest;
        if (s2_sum == '0 || norm_exp[9] || norm_exp == '0) begin
            out.data.raw <= '0;
        end else if (norm_exp >= 10'd255) begin
            out.data.fields <= '{sign: s2_sign, exponent: 8'hff, mantissa: 23'd0};
        end else begin
            out.data.fields <= '{sign: s2_sign, exponent: norm_exp[7:0], mantissa: norm_mant};
        end
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= s2_valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_mul_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage single precision multiplier with truncation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  alu_types_pkg::alu_operand_t in,
    output alu_types_pkg::alu_result_t  out
);

    logic        s1_valid;
    logic [7:0]  s1_dest;
    logic        s1_sign;
    logic        s1_zero;
    logic [9:0]  s1_exp_sum;
    logic [47:0] s1_prod;

    logic [9:0]  norm_exp;
    logic [22:0] norm_mant;

    always_ff @(posedge clock) begin
        s1_dest    <= in.dest;
        s1_sign    <= in.a.fields.sign ^ in.b.fields.sign;
        s1_zero    <= (in.a.fields.exponent == 8'd0) || (in.b.fields.exponent == 8'd0);
        s1_exp_sum <= {2'b00, in.a.fields.exponent} + {2'b00, in.b.fields.exponent};
        s1_prod    <= 48'(alu_types_pkg::with_hidden(in.a.fields))
                      * 48'(alu_types_pkg::with_hidden(in.b.fields));
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in.valid;
        end
    end

    // The product of two 1.x mantissas lies in [1, 4), so one bit of shift is enough
    always_comb begin
        norm_exp  = s1_exp_sum + {9'd0, s1_prod[47]} - 10'd127;
        norm_mant = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
    end

    always_ff @(posedge clock) begin
        out.dest <= s1_dest;
        if (s1_zero || norm_exp[9] || norm_exp == '0) begin
            out.data.raw <= '0;
        end else if (norm_exp >= 10'd255) begin
            out.data.fields <= '{sign: s1_sign, exponent: 8'hff, mantissa: 23'd0};
        end else begin
            out.data.fields <= '{sign: s1_sign, exponent: norm_exp[7:0], mantissa: norm_mant};
        end
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_compare_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-stage float comparison for the branch tests and the upper and
// lower saturation operations
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fp_compare_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  alu_types_pkg::alu_operand_t in,
    input  fcore_isa_pkg::opcode_t      opcode,
    output alu_types_pkg::alu_result_t  out
);

    logic [30:0] mag_a;
    logic [30:0] mag_b;
    logic        neg_a;
    logic        neg_b;
    logic        a_gt_b;
    logic        a_eq_b;

    // Any zero becomes +0 before ordering
    always_comb begin
        mag_a  = (in.a.fields.exponent == 8'd0) ? 31'd0 : in.a.raw[30:0];
        mag_b  = (in.b.fields.exponent == 8'd0) ? 31'd0 : in.b.raw[30:0];
        neg_a  = in.a.fields.sign && (mag_a != 31'd0);
        neg_b  = in.b.fields.sign && (mag_b != 31'd0);
        a_eq_b = (neg_a == neg_b) && (mag_a == mag_b);
        if (neg_a != neg_b) begin
            a_gt_b = neg_b;
        end else if (neg_a) begin
            a_gt_b = mag_a < mag_b;
        end else begin
            a_gt_b = mag_a > mag_b;
        end
    end

    always_ff @(posedge clock) begin
        out.dest <= in.dest;
        case (opcode)
            fcore_isa_pkg::BGT:  out.data.raw <= {31'd0, a_gt_b};
            fcore_isa_pkg::BLE:  out.data.raw <= {31'd0, !a_gt_b};
            fcore_isa_pkg::BEQ:  out.data.raw <= {31'd0, a_eq_b};
            fcore_isa_pkg::BNE:  out.data.raw <= {31'd0, !a_eq_b};
            // Upper clamp keeps the smaller value, lower clamp the larger
            fcore_isa_pkg::SATP: out.data <= a_gt_b ? in.b : in.a;
            fcore_isa_pkg::SATN: out.data <= a_gt_b ? in.a : in.b;
            default:             out.data.raw <= '0;
        endcase
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bitwise_logic_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-stage bitwise unit with and, or, not and population count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bitwise_logic_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  alu_types_pkg::alu_operand_t in,
    input  fcore_isa_pkg::opcode_t      opcode,
    output alu_types_pkg::alu_result_t  out
);

    logic [3:0] byte_count [4];
    logic [4:0] pair_low;
    logic [4:0] pair_high;
    logic [5:0] pop_total;

    // Population count as four byte counters and a two-level adder tree
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            byte_count[n] = '0;
            for (int i = 0; i < 8; i++) begin
                byte_count[n] = byte_count[n] + {3'd0, in.a.raw[8*n+i]};
            end
        end
        pair_low  = {1'b0, byte_count[0]} + {1'b0, byte_count[1]};
        pair_high = {1'b0, byte_count[2]} + {1'b0, byte_count[3]};
        pop_total = {1'b0, pair_low} + {1'b0, pair_high};
    end

    always_ff @(posedge clock) begin
        out.dest <= in.dest;
        case (opcode)
            fcore_isa_pkg::LAND:   out.data.raw <= in.a.raw & in.b.raw;
            fcore_isa_pkg::LOR:    out.data.raw <= in.a.raw | in.b.raw;
            fcore_isa_pkg::LNOT:   out.data.raw <= ~in.a.raw;
            fcore_isa_pkg::POPCNT: out.data.raw <= {26'd0, pop_total};
            default:               out.data.raw <= '0;
        endcase
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fp_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Floating point execution unit top level.
// Issues to the functional units, pads every path to PIPELINE_DEPTH
// and selects the result with the delayed opcode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fp_alu #(
    parameter int PIPELINE_DEPTH = 5
) (
    input  logic                        clock,
    input  logic                        reset,
    input  alu_types_pkg::alu_operand_t issue,
    input  fcore_isa_pkg::opcode_t      opcode,
    output alu_types_pkg::alu_result_t  result
);

    // Result paths are numbered add, mul, compare, logic, load
    localparam int N_PATHS    = 5;
    localparam int PATH_NONE  = N_PATHS;
    localparam int WORD_WIDTH = alu_types_pkg::REG_ADDR_WIDTH + alu_types_pkg::DATA_WIDTH;

    function automatic int path_of(fcore_isa_pkg::opcode_t op);
        case (op)
            fcore_isa_pkg::ADD, fcore_isa_pkg::SUB: return 0;
            fcore_isa_pkg::MUL: return 1;
            fcore_isa_pkg::BGT, fcore_isa_pkg::BLE, fcore_isa_pkg::BEQ, fcore_isa_pkg::BNE,
            fcore_isa_pkg::SATP, fcore_isa_pkg::SATN: return 2;
            fcore_isa_pkg::LAND, fcore_isa_pkg::LOR, fcore_isa_pkg::LNOT,
            fcore_isa_pkg::POPCNT: return 3;
            fcore_isa_pkg::LDR: return 4;
            default: return PATH_NONE;
        endcase
    endfunction

    function automatic int unit_latency(int path);
        case (path)
            0: return 3;
            1: return 2;
            2, 3: return 1;
            default: return 0;
        endcase
    endfunction

    int                                     issue_path;
    int                                     out_path;
    alu_types_pkg::alu_operand_t            unit_in [4];
    alu_types_pkg::alu_result_t             unit_out [N_PATHS];
    alu_types_pkg::alu_result_t             padded [N_PATHS];
    logic                                   op_valid;
    logic [fcore_isa_pkg::OPCODE_WIDTH-1:0] op_word;

    assign issue_path = path_of(opcode);

    // Each unit only sees a valid strobe for its own opcodes
    for (genvar p = 0; p < 4; p++) begin : g_issue
        assign unit_in[p] = '{valid: issue.valid && (issue_path == p), dest: issue.dest,
                              a: issue.a, b: issue.b};
    end

    fp_add_unit u_add (
        .clock (clock),
        .reset (reset),
        .in    (unit_in[0]),
        .opcode(opcode),
        .out   (unit_out[0])
    );

    fp_mul_unit u_mul (
        .clock(clock),
        .reset(reset),
        .in   (unit_in[1]),
        .out  (unit_out[1])
    );

    fp_compare_unit u_compare (
        .clock (clock),
        .reset (reset),
        .in    (unit_in[2]),
        .opcode(opcode),
        .out   (unit_out[2])
    );

    bitwise_logic_unit u_logic (
        .clock (clock),
        .reset (reset),
        .in    (unit_in[3]),
        .opcode(opcode),
        .out   (unit_out[3])
    );

    // Load register has no unit, operand a goes straight into its delay line
    assign unit_out[4] = '{valid: issue.valid && (issue_path == 4), dest: issue.dest,
                           data: issue.a};

    for (genvar p = 0; p < N_PATHS; p++) begin : g_pad
        logic                  pad_valid;
        logic [WORD_WIDTH-1:0] pad_word;

        delay_line #(
            .WIDTH (WORD_WIDTH),
            .STAGES(PIPELINE_DEPTH - unit_latency(p))
        ) u_pad (
            .clock    (clock),
            .reset    (reset),
            .in_valid (unit_out[p].valid),
            .in_word  ({unit_out[p].dest, unit_out[p].data}),
            .out_valid(pad_valid),
            .out_word (pad_word)
        );

        assign padded[p] = {pad_valid, pad_word};
    end

    delay_line #(
        .WIDTH (fcore_isa_pkg::OPCODE_WIDTH),
        .STAGES(PIPELINE_DEPTH)
    ) u_opcode_delay (
        .clock    (clock),
        .reset    (reset),
        .in_valid (issue.valid),
        .in_word  (opcode),
        .out_valid(op_valid),
        .out_word (op_word)
    );

    assign out_path = path_of(fcore_isa_pkg::opcode_t'(op_word));

    // An invalid opcode still occupies its slot but leaves valid low
    always_comb begin
        if (op_valid && out_path != PATH_NONE) begin
            result = padded[out_path];
        end else begin
            result = '0;
        end
    end

endmodule

`default_nettype wire

//--- testbench/fp_alu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the floating point execution unit: a stimulus table
// applied one instruction per cycle, random bitwise instructions,
// compare tasks and a cycle-limited monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fp_alu_tb;

    localparam int PIPELINE_DEPTH = 5;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_VECTORS    = 27;
    localparam int RANDOM_COUNT   = 20;
    localparam int NAME_CHARS     = 12;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + RANDOM_COUNT
                                    + PIPELINE_DEPTH + 20;

    typedef logic [8*NAME_CHARS-1:0] name_t;

    typedef struct packed {
        name_t                                    name;
        fcore_isa_pkg::opcode_t                   opcode;
        alu_types_pkg::fp_word_u                  a;
        alu_types_pkg::fp_word_u                  b;
        logic [alu_types_pkg::REG_ADDR_WIDTH-1:0] dest;
        alu_types_pkg::fp_word_u                  data;
        logic                                     valid;
    } vector_t;

    typedef struct packed {
        name_t                                    name;
        logic                                     valid;
        logic [alu_types_pkg::REG_ADDR_WIDTH-1:0] dest;
        alu_types_pkg::fp_word_u                  data;
        int unsigned                              due;
    } expect_t;

    // Name, opcode, a, b, dest, expected data, expected valid
    localparam vector_t VECTORS [NUM_VECTORS] = '{
        '{"add_basic", fcore_isa_pkg::ADD, 32'h3fc00000, 32'h40100000, 8'h01, 32'h40700000, 1'b1},
        '{"sub_neg", fcore_isa_pkg::SUB, 32'h40400000, 32'h40a00000, 8'h02, 32'hc0000000, 1'b1},
        '{"sub_cancel", fcore_isa_pkg::SUB, 32'h40000000, 32'h40000000, 8'h03, 32'h0, 1'b1},
        '{"add_ovf", fcore_isa_pkg::ADD, 32'h7f7fffff, 32'h7f7fffff, 8'h04, 32'h7f800000, 1'b1},
        '{"add_zero", fcore_isa_pkg::ADD, 32'h00000000, 32'h3fc00000, 8'h05, 32'h3fc00000, 1'b1},
        '{"mul_sign", fcore_isa_pkg::MUL, 32'h40000000, 32'hbf400000, 8'h06, 32'hbfc00000, 1'b1},
        '{"mul_carry", fcore_isa_pkg::MUL, 32'h40400000, 32'h40400000, 8'h07, 32'h41100000, 1'b1},
        '{"mul_zero", fcore_isa_pkg::MUL, 32'h00000000, 32'h40400000, 8'h08, 32'h0, 1'b1},
        '{"mul_ovf", fcore_isa_pkg::MUL, 32'h7149f2ca, 32'h7149f2ca, 8'h09, 32'h7f800000, 1'b1},
        '{"bgt_true", fcore_isa_pkg::BGT, 32'h40000000, 32'h3fc00000, 8'h0a, 32'h1, 1'b1},
        '{"bgt_neg", fcore_isa_pkg::BGT, 32'hc0400000, 32'hc0000000, 8'h0b, 32'h0, 1'b1},
        '{"ble_neg", fcore_isa_pkg::BLE, 32'hc0400000, 32'hc0000000, 8'h0c, 32'h1, 1'b1},
        '{"beq_zeros", fcore_isa_pkg::BEQ, 32'h00000000, 32'h80000000, 8'h0d, 32'h1, 1'b1},
        '{"bne_diff", fcore_isa_pkg::BNE, 32'h3fc00000, 32'h40100000, 8'h0e, 32'h1, 1'b1},
        '{"beq_diff", fcore_isa_pkg::BEQ, 32'h3fc00000, 32'h40100000, 8'h0f, 32'h0, 1'b1},
        '{"satp_clamp", fcore_isa_pkg::SATP, 32'h40a00000, 32'h40400000, 8'h10, 32'h40400000, 1'b1},
        '{"satn_clamp", fcore_isa_pkg::SATN, 32'hc0a00000, 32'hc0000000, 8'h11, 32'hc0000000, 1'b1},
        '{"land", fcore_isa_pkg::LAND, 32'hf0f01234, 32'h0ff0ff00, 8'h12, 32'h00f01200, 1'b1},
        '{"lor", fcore_isa_pkg::LOR, 32'hf000000f, 32'h00000ff0, 8'h13, 32'hf0000fff, 1'b1},
        '{"lnot", fcore_isa_pkg::LNOT, 32'h12345678, 32'hffffffff, 8'h14, 32'hedcba987, 1'b1},
        '{"popcnt_mix", fcore_isa_pkg::POPCNT, 32'hffff0001, 32'h0, 8'h15, 32'h11, 1'b1},
        '{"popcnt_all", fcore_isa_pkg::POPCNT, 32'hffffffff, 32'h0, 8'h16, 32'h20, 1'b1},
        '{"ldr_pass", fcore_isa_pkg::LDR, 32'hdeadbeef, 32'h12345678, 8'h17, 32'hdeadbeef, 1'b1},
        '{"bad_opcode", fcore_isa_pkg::opcode_t'(5'd7),
          32'h11111111, 32'h22222222, 8'h18, 32'h0, 1'b0},
        '{"ldr_b2b", fcore_isa_pkg::LDR, 32'hcafef00d, 32'h0, 8'h19, 32'hcafef00d, 1'b1},
        '{"add_mixneg", fcore_isa_pkg::ADD, 32'hbfc00000, 32'h40100000, 8'h1a, 32'h3f400000, 1'b1},
        '{"satp_pass", fcore_isa_pkg::SATP, 32'h3f800000, 32'h40400000, 8'h1b, 32'h3f800000, 1'b1}
    };

    logic                        clock;
    logic                        reset;
    alu_types_pkg::alu_operand_t issue;
    fcore_isa_pkg::opcode_t      opcode;
    alu_types_pkg::alu_result_t  result;

    expect_t     expected_q [$];
    int unsigned cycle_count = 0;
    int          seed = 32'hf1c7a7e5;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        test_ok;

    fp_alu #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) DUT (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .opcode(opcode),
        .result(result)
    );

    always #5 clock = ~clock;

    task automatic check_word(input name_t name, input alu_types_pkg::fp_word_u expected,
                              input alu_types_pkg::fp_word_u actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s data expected %08h actual %08h",
                     name, expected.raw, actual.raw);
            test_ok = 1'b0;
            error_count++;
        end
    endtask

    task automatic check_dest(input name_t name,
                              input logic [alu_types_pkg::REG_ADDR_WIDTH-1:0] expected,
                              input logic [alu_types_pkg::REG_ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s dest expected %02h actual %02h", name, expected, actual);
            test_ok = 1'b0;
            error_count++;
        end
    endtask

    task automatic check_valid(input name_t name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s valid expected %0b actual %0b", name, expected, actual);
            test_ok = 1'b0;
            error_count++;
        end
    endtask

    task automatic finish_test(input expect_t e);
        test_ok = 1'b1;
        check_valid(e.name, e.valid, result.valid);
        if (e.valid) begin
            check_dest(e.name, e.dest, result.dest);
        end
        check_word(e.name, e.data, result.data);
        tests_run++;
        if (test_ok) begin
            $display("%0s: ok", e.name);
        end else begin
            $display("%0s: failed", e.name);
            tests_failed++;
        end
    endtask

    // The DUT takes the word on the next rising edge, the result leaves
    // PIPELINE_DEPTH edges later and is sampled on the falling edge after that
    task automatic drive_slot(input vector_t v);
        @(posedge clock);
        issue  <= '{valid: 1'b1, dest: v.dest, a: v.a, b: v.b};
        opcode <= v.opcode;
        expected_q.push_back('{name: v.name, valid: v.valid, dest: v.dest, data: v.data,
                               due: cycle_count + PIPELINE_DEPTH + 1});
    endtask

    // Outputs are sampled on the falling edge, away from the driven edge
    always @(negedge clock) begin
        cycle_count = cycle_count + 1;
        if (expected_q.size() != 0 && expected_q[0].due == cycle_count) begin
            finish_test(expected_q.pop_front());
        end else if (result.valid !== 1'b0) begin
            $display("result.valid is high at cycle %0d with no instruction due", cycle_count);
            error_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results still outstanding",
                     cycle_count, expected_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        vector_t     v;
        int unsigned sel;
        clock  = 1'b0;
        reset  = 1'b1;
        issue  = '0;
        opcode = fcore_isa_pkg::LDR;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        // Idle cycles after reset, valid must stay low until the first issue
        repeat (3) @(posedge clock);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            drive_slot(VECTORS[i]);
        end

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            v.a.raw = $random(seed);
            v.b.raw = $random(seed);
            v.dest  = 8'(8'h40 + i);
            v.valid = 1'b1;
            sel     = $unsigned($random(seed)) % 3;
            case (sel)
                0: begin
                    v.name     = "rand_land";
                    v.opcode   = fcore_isa_pkg::LAND;
                    v.data.raw = v.a.raw & v.b.raw;
                end
                1: begin
                    v.name     = "rand_lor";
                    v.opcode   = fcore_isa_pkg::LOR;
                    v.data.raw = v.a.raw | v.b.raw;
                end
                default: begin
                    v.name     = "rand_lnot";
                    v.opcode   = fcore_isa_pkg::LNOT;
                    v.data.raw = ~v.a.raw;
                end
            endcase
            drive_slot(v);
        end

        @(posedge clock);
        issue <= '0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (2) @(negedge clock);

        $display("tests run %0d, failed %0d, mismatches and other errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_run == NUM_VECTORS + RANDOM_COUNT) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fp_alu.f
verilog/fcore_isa_pkg.sv
verilog/alu_types_pkg.sv
verilog/delay_line.sv
verilog/fp_add_unit.sv
verilog/fp_mul_unit.sv
verilog/fp_compare_unit.sv
verilog/bitwise_logic_unit.sv
verilog/fp_alu.sv
testbench/fp_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fp_alu testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
    verilator --binary --timing -f fp_alu.f --top-module fp_alu_tb -o fp_alu_sim &&
    ./obj_dir/fp_alu_sim | tee sim.log &&
    ! grep -q "TEST FAIL" sim.log &&
    grep -q "TEST PASS" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
